//--- neoVideo.f
common/neoVideoPkg.sv
verilog/neoPalette.sv
verilog/videoOut.sv
verilog/serVideo.sv
verilog/neoVideo.sv
verif/neoVideoTb.sv

//--- Makefile
# Verilator build and run of the palette and video output testbench

TOP = neoVideoTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the Verilator build folder"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f neoVideo.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

//--- verif/neoVideoTb.sv
`timescale 1ns/100ps

module neoVideoTb import neoVideoPkg::*; ();

	localparam int PIX_DIV    = 8;
	localparam int CLK_PERIOD = 20;
	localparam int NUM_ADDR   = 64;		// Words written per bank
	localparam int NUM_WR     = 2 * NUM_ADDR + 4;
	localparam int NUM_RD     = 2 * NUM_ADDR;
	localparam int NUM_PIX    = 48 + 32 + 8;
	localparam int WD_CYCLES  = NUM_WR + NUM_RD + NUM_PIX * PIX_DIV + 100;

	logic        clk24M = 1'b0;
	logic        rstN;
	logic [11:0] cpuAddr;
	logic        palBnk;
	logic [15:0] cpuDataIn;
	logic [15:0] cpuDataOut;
	logic        nPal;
	logic        cpuRw;
	pixReqT      pixIn;
	logic        pixEn;
	logic        videoRSer;
	logic        videoGSer;
	logic        videoBSer;
	logic        videoClkSer;
	logic        videoLatSer;

	logic [15:0] model [0:8191];		// Reference palette
	logic [15:0] rdExp;
	rgbT         expArr [0:255];		// Expected pixels by pixEn order
	rgbT         expNow;
	rgbT         capRgb;			// Bits collected from the serial port
	int          putCnt;
	int          latCnt;
	int          sinceEn;
	int          hiRun;
	int          errCnt = 0;
	int          seed = 99;

	neoVideo #(.pixDiv(PIX_DIV)) i_dut (.*);

	always #(CLK_PERIOD / 2) clk24M = ~clk24M;

	// Color word to 7-bit channels: level, then inverted dark twice
	function automatic rgbT refColor(input logic [15:0] w, input logic sh, input logic bl);
		rgbT c;
		c.r = {w[11:8], w[14], ~w[15], ~w[15]};
		c.g = {w[7:4], w[13], ~w[15], ~w[15]};
		c.b = {w[3:0], w[12], ~w[15], ~w[15]};
		if (sh) begin
			c.r = c.r >> 1;
			c.g = c.g >> 1;
			c.b = c.b >> 1;
		end
		if (bl)
			c = '0;
		return c;
	endfunction

	// Model follows every write strobe the DUT sees
	always @(posedge clk24M) begin
		if (!nPal && !cpuRw)
			model[{palBnk, cpuAddr}] <= cpuDataIn;
		if (!nPal && cpuRw)
			rdExp <= model[{palBnk, cpuAddr}];
		if (!rstN) begin
			sinceEn <= 0;
			putCnt  <= 0;
			latCnt  <= 0;
			hiRun   <= 0;
		end else begin
			sinceEn <= pixEn ? 1 : sinceEn + 1;
			if (pixEn) begin
				expArr[putCnt[7:0]] <= refColor(model[{palBnk, pixIn.idx}],
					pixIn.shadow, pixIn.blank);
				putCnt <= putCnt + 1;
			end
			if (videoClkSer) begin
				capRgb.r <= {capRgb.r[CHAN_W-2:0], videoRSer};	// MSB arrives first
				capRgb.g <= {capRgb.g[CHAN_W-2:0], videoGSer};
				capRgb.b <= {capRgb.b[CHAN_W-2:0], videoBSer};
			end
			hiRun <= videoClkSer ? hiRun + 1 : 0;
			if (videoLatSer)
				latCnt <= latCnt + 1;
		end
	end

	assign expNow = expArr[latCnt[7:0]];

	aIdle: assert property (@(posedge clk24M) disable iff (!rstN)
		putCnt == 0 && sinceEn < PIX_DIV |-> !pixEn && !videoClkSer && !videoLatSer)
		else begin
			errCnt = errCnt + 1;
			$display("Control output went high before the first pixel enable");
		end

	aPixPeriod: assert property (@(posedge clk24M) disable iff (!rstN)
		pixEn == (sinceEn == PIX_DIV))
		else begin
			errCnt = errCnt + 1;
			$display("pixEn did not pulse exactly every %0d cycles", PIX_DIV);
		end

	aReadback: assert property (@(posedge clk24M) disable iff (!rstN)
		!nPal && cpuRw |=> cpuDataOut == rdExp)
		else begin
			errCnt = errCnt + 1;
			$display("ERR cpuDataOut exp %h got %h", $sampled(rdExp), $sampled(cpuDataOut));
		end

	aFirstBit: assert property (@(posedge clk24M) disable iff (!rstN)
		$rose(videoClkSer) == $past(pixEn, 3))
		else begin
			errCnt = errCnt + 1;
			$display("First serial bit did not follow pixEn by three cycles");
		end

	aBitCount: assert property (@(posedge clk24M) disable iff (!rstN)
		$fell(videoClkSer) |-> hiRun == CHAN_W)
		else begin
			errCnt = errCnt + 1;
			$display("videoClkSer was high for %0d cycles instead of seven", $sampled(hiRun));
		end

	aLatch: assert property (@(posedge clk24M) disable iff (!rstN)
		videoLatSer == $fell(videoClkSer))
		else begin
			errCnt = errCnt + 1;
			$display("videoLatSer did not pulse once right after the last bit");
		end

	aPixel: assert property (@(posedge clk24M) disable iff (!rstN)
		videoLatSer |-> capRgb == expNow)
		else begin
			errCnt = errCnt + 1;
			$display("ERR videoR/G/BSer exp %h/%h/%h got %h/%h/%h",
				$sampled(expNow.r), $sampled(expNow.g), $sampled(expNow.b),
				$sampled(capRgb.r), $sampled(capRgb.g), $sampled(capRgb.b));
		end

	task automatic writeWord(input logic [11:0] addr, input logic bnk, input logic [15:0] data);
		cpuAddr   <= addr;
		palBnk    <= bnk;
		cpuDataIn <= data;
		nPal      <= 1'b0;
		cpuRw     <= 1'b0;
		@(posedge clk24M);
		nPal  <= 1'b1;
		cpuRw <= 1'b1;
	endtask

	task automatic readWord(input logic [11:0] addr, input logic bnk);
		cpuAddr <= addr;
		palBnk  <= bnk;
		nPal    <= 1'b0;
		cpuRw   <= 1'b1;
		@(posedge clk24M);
		nPal <= 1'b1;
	endtask

	// Present a pixel and return at the edge that takes it
	task automatic sendPixel(input logic [11:0] idx, input logic bnk, input logic sh,
		input logic bl);
		pixIn  <= '{idx: idx, shadow: sh, blank: bl};
		palBnk <= bnk;
		do @(posedge clk24M); while (!pixEn);
	endtask

	initial begin
		int          rnd;
		logic [11:0] addr;
		logic        bnk;
		int          target;
		rstN      = 1'b0;
		nPal      = 1'b1;
		cpuRw     = 1'b1;
		cpuAddr   = '0;
		palBnk    = 1'b0;
		cpuDataIn = '0;
		pixIn     = '{idx: '0, shadow: 1'b0, blank: 1'b1};	// Idle pixels are black
		repeat (4) @(posedge clk24M);
		rstN <= 1'b1;

		for (int b = 0; b < 2; b++)
			for (int a = 0; a < NUM_ADDR; a++)
				writeWord(a[11:0], b[0], 16'($random(seed)));
		for (int b = 0; b < 2; b++)
			for (int a = 0; a < NUM_ADDR; a++)
				readWord(a[11:0], b[0]);

		for (int i = 0; i < 48; i++) begin
			rnd = $random(seed);
			sendPixel(12'(rnd[5:0]), rnd[8], 1'b0, 1'b0);
		end
		// Every shadow and blank combination
		for (int i = 0; i < 32; i++) begin
			rnd = $random(seed);
			sendPixel(12'(rnd[5:0]), rnd[8], i[0], i[1]);
		end
		// Rewrite an index between two lookups of it
		for (int i = 0; i < 4; i++) begin
			rnd  = $random(seed);
			addr = 12'(rnd[5:0]);
			bnk  = rnd[8];
			sendPixel(addr, bnk, 1'b0, 1'b0);
			writeWord(addr, bnk, 16'($random(seed)));
			sendPixel(addr, bnk, 1'b0, 1'b0);
		end

		pixIn  <= '{idx: '0, shadow: 1'b0, blank: 1'b1};
		target = putCnt + 1;
		while (latCnt < target)
			@(posedge clk24M);
		@(posedge clk24M);

		$display("Errors: %0d", errCnt);
		if (errCnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("Timeout: run still busy after %0d clock cycles", WD_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- verilog/neoVideo.sv
`timescale 1ns/100ps

module neoVideo import neoVideoPkg::*; #(
	parameter int pixDiv = PIX_DIV_DEFAULT
) (
	input  logic        clk24M,
	input  logic        rstN,

	// 68K palette access
	input  logic [11:0] cpuAddr,
	input  logic        palBnk,
	input  logic [15:0] cpuDataIn,
	output logic [15:0] cpuDataOut,
	input  logic        nPal,
	input  logic        cpuRw,

	// Pixel stream from the sprite and fix layers
	input  pixReqT      pixIn,
	output logic        pixEn,

	// Serial video port
	output logic        videoRSer,
	output logic        videoGSer,
	output logic        videoBSer,
	output logic        videoClkSer,
	output logic        videoLatSer
);

	palOutT palOut;
	logic   palValid;
	rgbT    rgb;
	logic   rgbValid;

	neoPalette #(
		.pixDiv     (pixDiv)
	) i_palette (
		.clk24M     (clk24M),
		.rstN       (rstN),
		.cpuAddr    (cpuAddr),
		.palBnk     (palBnk),
		.cpuDataIn  (cpuDataIn),
		.cpuDataOut (cpuDataOut),
		.nPal       (nPal),
		.cpuRw      (cpuRw),
		.pixIn      (pixIn),
		.pixEn      (pixEn),
		.palOut     (palOut),
		.palValid   (palValid)
	);

	videoOut i_videoOut (
		.clk24M     (clk24M),
		.rstN       (rstN),
		.palOut     (palOut),
		.palValid   (palValid),
		.rgb        (rgb),
		.rgbValid   (rgbValid)
	);

	serVideo i_serVideo (
		.clk24M      (clk24M),
		.rstN        (rstN),
		.rgb         (rgb),
		.rgbValid    (rgbValid),
		.videoRSer   (videoRSer),
		.videoGSer   (videoGSer),
		.videoBSer   (videoBSer),
		.videoClkSer (videoClkSer),
		.videoLatSer (videoLatSer)
	);

endmodule

//--- verilog/serVideo.sv
`timescale 1ns/100ps

module serVideo import neoVideoPkg::*; (
	input  logic clk24M,
	input  logic rstN,
	input  rgbT  rgb,
	input  logic rgbValid,
	output logic videoRSer,
	output logic videoGSer,
	output logic videoBSer,
	output logic videoClkSer,
	output logic videoLatSer
);

	localparam int BIT_W = $clog2(CHAN_W + 1);

	logic [CHAN_W-1:0] shR;
	logic [CHAN_W-1:0] shG;
	logic [CHAN_W-1:0] shB;
	logic [BIT_W-1:0]  bitCnt;		// Bits still to send, current one included

	// Zeros shift in behind the data, lines rest at 0
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			shR <= '0;
			shG <= '0;
			shB <= '0;
		end else if (rgbValid) begin
			shR <= rgb.r;
			shG <= rgb.g;
			shB <= rgb.b;
		end else begin
			shR <= {shR[CHAN_W-2:0], 1'b0};
			shG <= {shG[CHAN_W-2:0], 1'b0};
			shB <= {shB[CHAN_W-2:0], 1'b0};
		end
	end

	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			bitCnt      <= '0;
			videoLatSer <= 1'b0;
		end else begin
			if (rgbValid)
				bitCnt <= BIT_W'(CHAN_W);
			else if (bitCnt != '0)
				bitCnt <= bitCnt - 1'b1;
			// Latch right after the last bit
			videoLatSer <= (bitCnt == BIT_W'(1)) && !rgbValid;
		end
	end

	assign videoRSer   = shR[CHAN_W-1];	// MSB first
	assign videoGSer   = shG[CHAN_W-1];
	assign videoBSer   = shB[CHAN_W-1];
	assign videoClkSer = (bitCnt != '0);

	// Pixel rate must leave room for a whole word
	aNoOverrun: assert property (@(posedge clk24M) disable iff (!rstN)
		rgbValid |-> bitCnt == '0)
		else $error("serVideo: new pixel while shifting");

endmodule

//--- verilog/videoOut.sv
`timescale 1ns/100ps

module videoOut import neoVideoPkg::*; (
	input  logic   clk24M,
	input  logic   rstN,
	input  palOutT palOut,
	input  logic   palValid,
	output rgbT    rgb,
	output logic   rgbValid
);

	rgbT rgbNext;

	// 5-bit level, then the inverted dark bit twice
	function automatic logic [CHAN_W-1:0] chanLevel(
		input logic [3:0] hi,
		input logic       lsb,
		input logic       dark,
		input logic       shadow
	);
		logic [CHAN_W-1:0] lvl;
		lvl = {hi, lsb, ~dark, ~dark};
		if (shadow)
			lvl = lvl >> 1;		// Half brightness
		return lvl;
	endfunction

	always_comb begin
		if (palOut.blank) begin
			rgbNext = '0;		// Blank wins over shadow
		end else begin
			rgbNext.r = chanLevel(palOut.color.col.rHi, palOut.color.col.rLsb,
				palOut.color.col.dark, palOut.shadow);
			rgbNext.g = chanLevel(palOut.color.col.gHi, palOut.color.col.gLsb,
				palOut.color.col.dark, palOut.shadow);
			rgbNext.b = chanLevel(palOut.color.col.bHi, palOut.color.col.bLsb,
				palOut.color.col.dark, palOut.shadow);
		end
	end

	always_ff @(posedge clk24M) begin
		if (palValid)
			rgb <= rgbNext;
	end

	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN)
			rgbValid <= 1'b0;
		else
			rgbValid <= palValid;
	end

	aBlankBlack: assert property (@(posedge clk24M) disable iff (!rstN)
		palValid && palOut.blank |=> rgb == '0)
		else $error("videoOut: blanked pixel not black");

endmodule

//--- verilog/neoPalette.sv
`timescale 1ns/100ps

module neoPalette import neoVideoPkg::*; #(
	parameter int pixDiv = PIX_DIV_DEFAULT
) (
	input  logic        clk24M,
	input  logic        rstN,

	// 68K side
	input  logic [11:0] cpuAddr,
	input  logic        palBnk,
	input  logic [15:0] cpuDataIn,
	output logic [15:0] cpuDataOut,
	input  logic        nPal,		// Chip select, active low
	input  logic        cpuRw,		// High = read

	// Pixel side
	input  pixReqT      pixIn,
	output logic        pixEn,
	output palOutT      palOut,
	output logic        palValid
);

	localparam int CNT_W = $clog2(pixDiv);

	// Two banks of 4K words, bank bit on top
	palWordT palRam [0:8191];

	logic [CNT_W-1:0] divCnt;
	logic             nPalWe;
	logic             cpuRd;
	logic [12:0]      cpuIdx;
	logic [12:0]      pixIdx;

	assign nPalWe = cpuRw | nPal;
	assign cpuRd  = cpuRw & ~nPal;
	assign cpuIdx = {palBnk, cpuAddr};
	assign pixIdx = {palBnk, pixIn.idx};

	// Pixel rate divider, one pulse every pixDiv cycles
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			divCnt <= '0;
			pixEn  <= 1'b0;
		end else if (divCnt == CNT_W'(pixDiv - 1)) begin
			divCnt <= '0;
			pixEn  <= 1'b1;
		end else begin
			divCnt <= divCnt + 1'b1;
			pixEn  <= 1'b0;
		end
	end

	// CPU port
	always_ff @(posedge clk24M) begin
		if (!nPalWe)
			palRam[cpuIdx].raw <= cpuDataIn;
		if (cpuRd)
			cpuDataOut <= palRam[cpuIdx].raw;	// Held until next read
	end

	// Pixel lookup port, sees the old word on a colliding write
	always_ff @(posedge clk24M) begin
		if (pixEn) begin
			palOut.color  <= palRam[pixIdx];
			palOut.shadow <= pixIn.shadow;
			palOut.blank  <= pixIn.blank;
		end
	end

	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN)
			palValid <= 1'b0;
		else
			palValid <= pixEn;
	end

	// Serializer needs 7 bits plus latch per pixel
	if (pixDiv < 8 || pixDiv > 16) begin : gDivRange
		$error("neoPalette: pixDiv %0d outside 8..16", pixDiv);
	end

	aCpuKnown: assert property (@(posedge clk24M) disable iff (!rstN)
		!nPal |-> !$isunknown({cpuAddr, cpuRw}))
		else $error("neoPalette: unknown address or rw with nPal low");

endmodule

//--- common/neoVideoPkg.sv
package neoVideoPkg;

	// Width of one output color channel
	localparam int CHAN_W = 7;

	// clk24M cycles per pixel unless the top level says otherwise
	localparam int PIX_DIV_DEFAULT = 8;

	// Color fields of a palette word, MSB first
	typedef struct packed {
		logic       dark;		// Shared by all three channels
		logic       rLsb;
		logic       gLsb;
		logic       bLsb;
		logic [3:0] rHi;
		logic [3:0] gHi;
		logic [3:0] bHi;
	} palColorT;

	// CPU sees raw data, decoder sees the color fields
	typedef union packed {
		logic [15:0] raw;
		palColorT    col;
	} palWordT;

	typedef struct packed {
		logic [11:0] idx;		// Palette index from the line buffers
		logic        shadow;	// Dim this pixel
		logic        blank;		// Force black
	} pixReqT;

	typedef struct packed {
		palWordT color;
		logic    shadow;
		logic    blank;
	} palOutT;

	typedef struct packed {
		logic [CHAN_W-1:0] r;
		logic [CHAN_W-1:0] g;
		logic [CHAN_W-1:0] b;
	} rgbT;

endpackage
